/* run.sh */
#!/bin/sh
# Build and run the serial link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f vlog.f --top-module tb_serial_link -Mdir obj_dir -o sim_serial_link

status=0
./obj_dir/sim_serial_link > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* serial_link.sv */
`timescale 1ns/1ns
// Single channel serial link
// Network, data link and physical layers with credit based flow control
module serial_link #(
  parameter int DataWidth  = serial_link_pkg::DataWidthDefault,
  parameter int NumLanes   = serial_link_pkg::NumLanesDefault,
  parameter int NumCredits = serial_link_pkg::NumCreditsDefault
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [serial_link_pkg::ClkDivWidth-1:0] clk_div_i,
  input  logic [DataWidth-1:0]                data_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  output logic [DataWidth-1:0]                data_o,
  output logic                                valid_o,
  input  logic                                ready_i,
  output logic                                ddr_clk_o,
  output logic [NumLanes-1:0]                 ddr_o,
  input  logic                                ddr_clk_i,
  input  logic [NumLanes-1:0]                 ddr_i
);

  import serial_link_pkg::*;

  localparam int PayloadBits = payload_bits(DataWidth);

  logic [PayloadBits-1:0]  tx_payload;
  logic                    tx_valid;
  logic                    tx_ready;
  logic [PayloadBits-1:0]  rx_payload;
  logic                    rx_valid;
  logic [2*NumLanes-1:0]   phy_tx_data;
  logic                    phy_tx_valid;
  logic                    phy_tx_ready;
  logic [2*NumLanes-1:0]   phy_rx_data;
  logic                    phy_rx_valid;

  ////////////////////////////////////////////////////////////
  // Network layer

  serial_link_network #(
    .DataWidth  ( DataWidth  ),
    .NumCredits ( NumCredits )
  ) i_serial_link_network (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .data_i       ( data_i     ),
    .valid_i      ( valid_i    ),
    .ready_o      ( ready_o    ),
    .data_o       ( data_o     ),
    .valid_o      ( valid_o    ),
    .ready_i      ( ready_i    ),
    .tx_payload_o ( tx_payload ),
    .tx_valid_o   ( tx_valid   ),
    .tx_ready_i   ( tx_ready   ),
    .rx_payload_i ( rx_payload ),
    .rx_valid_i   ( rx_valid   )
  );

  ////////////////////////////////////////////////////////////
  // Data link layer

  serial_link_data_link #(
    .DataWidth ( DataWidth ),
    .NumLanes  ( NumLanes  )
  ) i_serial_link_data_link (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .tx_payload_i   ( tx_payload   ),
    .tx_valid_i     ( tx_valid     ),
    .tx_ready_o     ( tx_ready     ),
    .rx_payload_o   ( rx_payload   ),
    .rx_valid_o     ( rx_valid     ),
    .phy_tx_data_o  ( phy_tx_data  ),
    .phy_tx_valid_o ( phy_tx_valid ),
    .phy_tx_ready_i ( phy_tx_ready ),
    .phy_rx_data_i  ( phy_rx_data  ),
    .phy_rx_valid_i ( phy_rx_valid )
  );

  ////////////////////////////////////////////////////////////
  // Physical layer

  serial_link_physical #(
    .NumLanes ( NumLanes )
  ) i_serial_link_physical (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .clk_div_i      ( clk_div_i    ),
    .phy_tx_data_i  ( phy_tx_data  ),
    .phy_tx_valid_i ( phy_tx_valid ),
    .phy_tx_ready_o ( phy_tx_ready ),
    .phy_rx_data_o  ( phy_rx_data  ),
    .phy_rx_valid_o ( phy_rx_valid ),
    .ddr_clk_o      ( ddr_clk_o    ),
    .ddr_o          ( ddr_o        ),
    .ddr_clk_i      ( ddr_clk_i    ),
    .ddr_i          ( ddr_i        )
  );

endmodule

/* serial_link_asserts.sv */
`timescale 1ns/1ns
// Network layer assertions
// Credit bound, FIFO overflow and transmit handshake stability
module serial_link_asserts #(
  parameter int NumCredits  = 4,
  parameter int PayloadBits = 21
) (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic [serial_link_pkg::CreditWidth-1:0] credit_cnt_i,
  input logic                                    fifo_push_i,
  input logic                                    fifo_full_i,
  input logic                                    tx_valid_i,
  input logic                                    tx_ready_i,
  input logic [PayloadBits-1:0]                  tx_payload_i
);

  import serial_link_pkg::*;

  int fail_count = 0;

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_i <= CreditWidth'(NumCredits))
    else begin
      $error("Credit count above the receive FIFO depth");
      fail_count++;
    end

  no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_push_i |-> !fifo_full_i)
    else begin
      $error("Push into a full receive FIFO");
      fail_count++;
    end

  // Payload held until the data link takes it
  tx_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_payload_i))
    else begin
      $error("Transmit payload changed before it was taken");
      fail_count++;
    end

endmodule

bind serial_link_network serial_link_asserts #(
  .NumCredits  ( NumCredits  ),
  .PayloadBits ( PayloadBits )
) i_serial_link_asserts (
  .clk_i        ( clk_i        ),
  .rst_n_i      ( rst_n_i      ),
  .credit_cnt_i ( credit_cnt_q ),
  .fifo_push_i  ( fifo_push    ),
  .fifo_full_i  ( fifo_full    ),
  .tx_valid_i   ( tx_valid_o   ),
  .tx_ready_i   ( tx_ready_i   ),
  .tx_payload_i ( tx_payload_o )
);

/* serial_link_checker.sv */
`timescale 1ns/1ns
// Serial link checker
// Predicts output words from accepted input words and checks the
// reset state, the words in flight and the lane clock timing
module serial_link_checker #(
  parameter int DataWidth  = 16,
  parameter int NumLanes   = 4,
  parameter int NumCredits = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [serial_link_pkg::ClkDivWidth-1:0] clk_div_i,
  input  logic [DataWidth-1:0]                    in_data_i,
  input  logic                                    in_valid_i,
  input  logic                                    in_ready_i,
  input  logic [DataWidth-1:0]                    out_data_i,
  input  logic                                    out_valid_i,
  input  logic                                    out_ready_i,
  input  logic                                    ddr_clk_i,
  input  logic [NumLanes-1:0]                     ddr_i,
  output int                                      error_count_o,
  output int                                      checked_count_o,
  output int                                      pending_o
);

  import serial_link_pkg::*;

  logic [DataWidth-1:0]   expected_q [$];
  logic [DataWidth-1:0]   expected;
  int                     errors = 0;
  int                     checked = 0;
  logic                   after_reset = 1'b1;
  logic                   ddr_clk_prev = 1'b0;
  logic                   have_ref = 1'b0;
  int                     since_toggle = 0;
  logic [ClkDivWidth-1:0] div_prev = '0;

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("FAIL %0t %s expected %0h got %0h", $time, name, exp_val, act_val);
    errors++;
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      expected_q.delete();
      after_reset  = 1'b1;
      have_ref     = 1'b0;
      ddr_clk_prev = 1'b0;
      since_toggle = 0;
      pending_o    <= 0;
    end else begin
      if (after_reset) begin
        if (out_valid_i !== 1'b0) report_mismatch("valid_o", 32'd0, 32'(out_valid_i));
        if (ddr_clk_i !== 1'b0) report_mismatch("ddr_clk_o", 32'd0, 32'(ddr_clk_i));
        if (ddr_i !== '0) report_mismatch("ddr_o", 32'd0, 32'(ddr_i));
        if (in_ready_i !== 1'b1) report_mismatch("ready_o", 32'd1, 32'(in_ready_i));
        after_reset = 1'b0;
      end

      ////////////////////////////////////////////////////////////
      // Stream words

      if (in_valid_i && in_ready_i) begin
        expected_q.push_back(in_data_i);
      end
      if (out_valid_i && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("Word delivered at %0t with no accepted word outstanding", $time);
          errors++;
        end else begin
          expected = expected_q.pop_front();
          if (out_data_i !== expected) begin
            report_mismatch("data_o", 32'(expected), 32'(out_data_i));
          end
          checked++;
        end
      end
      // FIFO plus the one transmit register
      if (expected_q.size() > NumCredits + 1) begin
        $display("Too many words in flight at %0t: %0d accepted and not delivered",
                 $time, expected_q.size());
        errors++;
      end

      ////////////////////////////////////////////////////////////
      // Lane clock spacing

      if (clk_div_i != div_prev) begin
        have_ref = 1'b0;
      end
      div_prev = clk_div_i;
      since_toggle++;
      if (ddr_clk_i != ddr_clk_prev) begin
        if (have_ref) begin
          // Falling toggle closes a phy word
          if (!ddr_clk_i && since_toggle != int'(clk_div_i)) begin
            $display("Lane clock fell %0d cycles after it rose at %0t, expected %0d",
                     since_toggle, $time, clk_div_i);
            errors++;
          end else if (since_toggle % int'(clk_div_i) != 0) begin
            $display("Lane clock toggled after %0d cycles at %0t, not a multiple of %0d",
                     since_toggle, $time, clk_div_i);
            errors++;
          end
        end
        have_ref     = 1'b1;
        since_toggle = 0;
      end
      ddr_clk_prev = ddr_clk_i;

      error_count_o   <= errors;
      checked_count_o <= checked;
      pending_o       <= expected_q.size();
    end
  end

endmodule

/* serial_link_data_link.sv */
`timescale 1ns/1ns
// Serial link data link layer
// Splits each payload into phy words, low part first, and reassembles
// received phy words into payloads
module serial_link_data_link #(
  parameter int DataWidth = serial_link_pkg::DataWidthDefault,
  parameter int NumLanes  = serial_link_pkg::NumLanesDefault
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [serial_link_pkg::payload_bits(DataWidth)-1:0] tx_payload_i,
  input  logic                                             tx_valid_i,
  output logic                                             tx_ready_o,
  output logic [serial_link_pkg::payload_bits(DataWidth)-1:0] rx_payload_o,
  output logic                                             rx_valid_o,
  output logic [2*NumLanes-1:0]                            phy_tx_data_o,
  output logic                                             phy_tx_valid_o,
  input  logic                                             phy_tx_ready_i,
  input  logic [2*NumLanes-1:0]                            phy_rx_data_i,
  input  logic                                             phy_rx_valid_i
);

  import serial_link_pkg::*;

  localparam int PayloadBits = payload_bits(DataWidth);
  localparam int PhyWidth    = 2 * NumLanes;
  localparam int Splits      = num_splits(DataWidth, NumLanes);
  localparam int BufBits     = Splits * PhyWidth;
  localparam int CntWidth    = (Splits > 1) ? $clog2(Splits) : 1;
  localparam logic [CntWidth-1:0] LastSplit = CntWidth'(Splits - 1);

  logic [BufBits-1:0]          tx_buf_q;
  logic [CntWidth-1:0]         tx_cnt_q;
  logic                        tx_busy_q;
  logic                        tx_accept;
  logic                        tx_beat;
  logic [BufBits+PhyWidth-1:0] rx_next;
  logic [BufBits-1:0]          rx_buf_q;
  logic [CntWidth-1:0]         rx_cnt_q;

  ////////////////////////////////////////////////////////////
  // Transmit split

  assign tx_ready_o     = !tx_busy_q;
  assign tx_accept      = tx_valid_i && tx_ready_o;
  assign tx_beat        = tx_busy_q && phy_tx_ready_i;
  assign phy_tx_valid_o = tx_busy_q;
  assign phy_tx_data_o  = tx_buf_q[PhyWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
    end else if (tx_accept) begin
      tx_busy_q <= 1'b1;
      tx_cnt_q  <= '0;
    end else if (tx_beat) begin
      if (tx_cnt_q == LastSplit) begin
        tx_busy_q <= 1'b0;
        tx_cnt_q  <= '0;
      end else begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
    end
  end

  // Zero padded above the payload, shifted down one phy word per beat
  always_ff @(posedge clk_i) begin
    if (tx_accept) begin
      tx_buf_q <= BufBits'(tx_payload_i);
    end else if (tx_beat) begin
      tx_buf_q <= tx_buf_q >> PhyWidth;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive reassembly

  // New words enter at the top so the first one ends up lowest
  assign rx_next      = {phy_rx_data_i, rx_buf_q};
  assign rx_payload_o = rx_buf_q[PayloadBits-1:0];

  always_ff @(posedge clk_i) begin
    if (phy_rx_valid_i) begin
      rx_buf_q <= rx_next[BufBits+PhyWidth-1:PhyWidth];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_cnt_q   <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (phy_rx_valid_i) begin
        if (rx_cnt_q == LastSplit) begin
          rx_cnt_q   <= '0;
          rx_valid_o <= 1'b1;
        end else begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

/* serial_link_network.sv */
`timescale 1ns/1ns
// Serial link network layer
// Packs stream words into tagged payloads, tracks credits toward the peer,
// returns owed credits and buffers received words in the receive FIFO
module serial_link_network #(
  parameter int DataWidth  = serial_link_pkg::DataWidthDefault,
  parameter int NumCredits = serial_link_pkg::NumCreditsDefault
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [DataWidth-1:0]                             data_i,
  input  logic                                             valid_i,
  output logic                                             ready_o,
  output logic [DataWidth-1:0]                             data_o,
  output logic                                             valid_o,
  input  logic                                             ready_i,
  output logic [serial_link_pkg::payload_bits(DataWidth)-1:0] tx_payload_o,
  output logic                                             tx_valid_o,
  input  logic                                             tx_ready_i,
  input  logic [serial_link_pkg::payload_bits(DataWidth)-1:0] rx_payload_i,
  input  logic                                             rx_valid_i
);

  import serial_link_pkg::*;

  localparam int PayloadBits = payload_bits(DataWidth);

  logic [CreditWidth-1:0] credit_cnt_q;
  logic [CreditWidth-1:0] credit_cnt_d;
  logic [CreditWidth-1:0] owed_cnt_q;
  logic [CreditWidth-1:0] owed_cnt_d;
  logic                   tx_free;
  logic                   send_data;
  logic                   send_credit;
  logic                   tx_load;
  logic [CreditWidth-1:0] rx_credit;
  tag_e                   rx_tag;
  logic                   fifo_push;
  logic                   fifo_pop;
  logic                   fifo_empty;
  logic                   fifo_full;

  ////////////////////////////////////////////////////////////
  // Transmit side

  // Register can take a new payload when empty or drained this cycle
  assign tx_free = !tx_valid_o || tx_ready_i;
  assign ready_o = tx_free && (credit_cnt_q != '0);

  // Data wins, a credit-only payload fills otherwise idle slots
  assign send_data   = valid_i && ready_o;
  assign send_credit = !send_data && tx_free && (owed_cnt_q != '0);
  assign tx_load     = send_data || send_credit;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_valid_o <= 1'b0;
    end else if (tx_free) begin
      tx_valid_o <= tx_load;
    end
  end

  // Every payload carries all credits owed so far
  always_ff @(posedge clk_i) begin
    if (send_data) begin
      tx_payload_o <= {data_i, TagData, owed_cnt_q};
    end else if (send_credit) begin
      tx_payload_o <= {{DataWidth{1'b0}}, TagCredit, owed_cnt_q};
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive side

  assign rx_credit = rx_payload_i[CreditWidth-1:0];
  assign rx_tag    = tag_e'(rx_payload_i[CreditWidth+:2]);
  assign fifo_push = rx_valid_i && (rx_tag == TagData);
  assign valid_o   = !fifo_empty;
  assign fifo_pop  = valid_o && ready_i;

  serial_link_recv_fifo #(
    .Depth     ( NumCredits ),
    .DataWidth ( DataWidth  )
  ) i_recv_fifo (
    .clk_i       ( clk_i                                    ),
    .rst_n_i     ( rst_n_i                                  ),
    .push_i      ( fifo_push                                ),
    .push_data_i ( rx_payload_i[PayloadBits-1-:DataWidth] ),
    .pop_i       ( fifo_pop                                 ),
    .pop_data_o  ( data_o                                   ),
    .empty_o     ( fifo_empty                               ),
    .full_o      ( fifo_full                                )
  );

  ////////////////////////////////////////////////////////////
  // Credit bookkeeping

  always_comb begin
    credit_cnt_d = credit_cnt_q;
    if (send_data) begin
      credit_cnt_d = credit_cnt_d - 1'b1;
    end
    if (rx_valid_i) begin
      credit_cnt_d = credit_cnt_d + rx_credit;
    end
    // A freed FIFO slot becomes a credit owed to the peer
    owed_cnt_d = tx_load ? '0 : owed_cnt_q;
    if (fifo_pop) begin
      owed_cnt_d = owed_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= CreditWidth'(NumCredits);
      owed_cnt_q   <= '0;
    end else begin
      credit_cnt_q <= credit_cnt_d;
      owed_cnt_q   <= owed_cnt_d;
    end
  end

endmodule

/* serial_link_physical.sv */
`timescale 1ns/1ns
// Serial link physical layer
// Drives a divided lane clock with one half phy word per edge and
// samples the incoming lanes on detected edges of the peer clock
module serial_link_physical #(
  parameter int NumLanes = serial_link_pkg::NumLanesDefault
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [serial_link_pkg::ClkDivWidth-1:0] clk_div_i,
  input  logic [2*NumLanes-1:0]               phy_tx_data_i,
  input  logic                                phy_tx_valid_i,
  output logic                                phy_tx_ready_o,
  output logic [2*NumLanes-1:0]               phy_rx_data_o,
  output logic                                phy_rx_valid_o,
  output logic                                ddr_clk_o,
  output logic [NumLanes-1:0]                 ddr_o,
  input  logic                                ddr_clk_i,
  input  logic [NumLanes-1:0]                 ddr_i
);

  import serial_link_pkg::*;

  logic [ClkDivWidth-1:0] div_cnt_q;
  logic                   tick;
  logic                   low_out_q;
  logic [NumLanes-1:0]    tx_hi_q;
  logic                   ddr_clk_in_q;
  logic                   rx_rise;
  logic                   rx_fall;
  logic [NumLanes-1:0]    rx_lo_q;
  logic [NumLanes-1:0]    rx_hi_q;

  ////////////////////////////////////////////////////////////
  // Transmit

  // Free running divider, so lane clock edges stay on its grid
  assign tick = ({1'b0, div_cnt_q} + 1'b1) >= {1'b0, clk_div_i};

  // A new word starts only on a tick with no first half on the lanes
  assign phy_tx_ready_o = tick && !low_out_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
      low_out_q <= 1'b0;
      ddr_clk_o <= 1'b0;
      ddr_o     <= '0;
    end else if (tick) begin
      div_cnt_q <= '0;
      if (low_out_q) begin
        // Falling edge carries the upper half
        ddr_clk_o <= 1'b0;
        ddr_o     <= tx_hi_q;
        low_out_q <= 1'b0;
      end else if (phy_tx_valid_i) begin
        ddr_clk_o <= 1'b1;
        ddr_o     <= phy_tx_data_i[NumLanes-1:0];
        low_out_q <= 1'b1;
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (phy_tx_ready_o && phy_tx_valid_i) begin
      tx_hi_q <= phy_tx_data_i[2*NumLanes-1:NumLanes];
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive

  assign rx_rise       = ddr_clk_i && !ddr_clk_in_q;
  assign rx_fall       = !ddr_clk_i && ddr_clk_in_q;
  assign phy_rx_data_o = {rx_hi_q, rx_lo_q};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ddr_clk_in_q   <= 1'b0;
      phy_rx_valid_o <= 1'b0;
    end else begin
      ddr_clk_in_q   <= ddr_clk_i;
      phy_rx_valid_o <= rx_fall;
    end
  end

  // Lanes are sampled the cycle after the edge is seen
  always_ff @(posedge clk_i) begin
    if (rx_rise) begin
      rx_lo_q <= ddr_i;
    end
    if (rx_fall) begin
      rx_hi_q <= ddr_i;
    end
  end

endmodule

/* serial_link_pkg.sv */
// Serial link shared definitions
// Payload tag, widths, default link constants and payload sizing helpers
package serial_link_pkg;

  // Kind of payload carried over the link
  typedef enum logic [1:0] {
    TagNone   = 2'd0,
    TagData   = 2'd1,
    TagCredit = 2'd2
  } tag_e;

  // Credit counts and the credit field share this width
  localparam int CreditWidth = 3;

  localparam int NumCreditsDefault = 4;
  localparam int DataWidthDefault  = 16;
  localparam int NumLanesDefault   = 4;

  // Lane clock divider configuration
  localparam int ClkDivWidth = 4;
  localparam int MaxClkDiv   = (1 << ClkDivWidth) - 1;

  // Data word, tag and credit field
  function automatic int payload_bits(input int data_width);
    return data_width + 2 + CreditWidth;
  endfunction

  // Phy words per payload, a phy word being two beats on the lanes
  function automatic int num_splits(input int data_width, input int num_lanes);
    return (payload_bits(data_width) + 2 * num_lanes - 1) / (2 * num_lanes);
  endfunction

endpackage

/* serial_link_recv_fifo.sv */
`timescale 1ns/1ns
// Serial link receive FIFO
// Circular buffer that holds received data words, one slot per credit
module serial_link_recv_fifo #(
  parameter int Depth     = 4,
  parameter int DataWidth = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 push_i,
  input  logic [DataWidth-1:0] push_data_i,
  input  logic                 pop_i,
  output logic [DataWidth-1:0] pop_data_o,
  output logic                 empty_o,
  output logic                 full_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  logic [DataWidth-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;

  // Pointer advance with wrap for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CntWidth'(Depth));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* tb_serial_link.sv */
`timescale 1ns/1ns
// Serial link testbench
// Loops the lanes back to the receiver and applies a table of stimulus rows,
// each drained through the credit loop before the next starts
module tb_serial_link;

  import serial_link_pkg::*;

  localparam int DataWidth  = DataWidthDefault;
  localparam int NumLanes   = NumLanesDefault;
  localparam int NumCredits = NumCreditsDefault;
  localparam int Splits     = num_splits(DataWidth, NumLanes);

  // Behavior of ready on the output stream
  localparam int ReadyAlways = 0;
  localparam int ReadyRandom = 1;
  localparam int ReadyStall  = 2;

  localparam int NumRows = 6;
  // clk_div, words, ready mode
  localparam int StimTable [NumRows][3] = '{
    '{ 1, 16, ReadyAlways},
    '{ 3, 10, ReadyAlways},
    '{15,  6, ReadyAlways},
    '{ 2, 12, ReadyStall },
    '{ 1, 24, ReadyRandom},
    '{ 4, 10, ReadyRandom}
  };

  logic                   clk;
  logic                   rst_n;
  logic [ClkDivWidth-1:0] clk_div;
  logic [DataWidth-1:0]   in_data;
  logic                   in_valid;
  logic                   in_ready;
  logic [DataWidth-1:0]   out_data;
  logic                   out_valid;
  logic                   out_ready;
  logic                   ddr_clk;
  logic [NumLanes-1:0]    ddr;
  logic [CreditWidth-1:0] credit_level;
  int                     assert_errors;
  int                     chk_errors;
  int                     checked;
  int                     pending;
  int                     stim_errors = 0;
  logic [31:0]            lfsr_q = 32'd84217;

  ////////////////////////////////////////////////////////////
  // Clock, DUT and checker

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Lanes and lane clock wired straight back to the receiver
  serial_link #(
    .DataWidth  ( DataWidth  ),
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits )
  ) serial_link_inst (
    .clk_i     ( clk       ),
    .rst_n_i   ( rst_n     ),
    .clk_div_i ( clk_div   ),
    .data_i    ( in_data   ),
    .valid_i   ( in_valid  ),
    .ready_o   ( in_ready  ),
    .data_o    ( out_data  ),
    .valid_o   ( out_valid ),
    .ready_i   ( out_ready ),
    .ddr_clk_o ( ddr_clk   ),
    .ddr_o     ( ddr       ),
    .ddr_clk_i ( ddr_clk   ),
    .ddr_i     ( ddr       )
  );

  serial_link_checker #(
    .DataWidth  ( DataWidth  ),
    .NumLanes   ( NumLanes   ),
    .NumCredits ( NumCredits )
  ) i_serial_link_checker (
    .clk_i           ( clk        ),
    .rst_n_i         ( rst_n      ),
    .clk_div_i       ( clk_div    ),
    .in_data_i       ( in_data    ),
    .in_valid_i      ( in_valid   ),
    .in_ready_i      ( in_ready   ),
    .out_data_i      ( out_data   ),
    .out_valid_i     ( out_valid  ),
    .out_ready_i     ( out_ready  ),
    .ddr_clk_i       ( ddr_clk    ),
    .ddr_i           ( ddr        ),
    .error_count_o   ( chk_errors ),
    .checked_count_o ( checked    ),
    .pending_o       ( pending    )
  );

  // Link is idle once every credit has come back
  assign credit_level = serial_link_inst.i_serial_link_network.credit_cnt_q;

  // Failures of the bound network assertions
  assign assert_errors =
    serial_link_inst.i_serial_link_network.i_serial_link_asserts.fail_count;

  ////////////////////////////////////////////////////////////
  // Random bits and timing budget

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Long enough for every credit to be spent with the output held off
  function automatic int stall_cycles(input int div);
    return NumCredits * (Splits * 2 * div + 10) + 20;
  endfunction

  function automatic int watchdog_cycles();
    int total;
    int r;
    total = 0;
    for (r = 0; r < NumRows; r++) begin
      total += StimTable[r][1] * (Splits * 2 * StimTable[r][0] + 10);
      if (StimTable[r][2] == ReadyStall) begin
        total += stall_cycles(StimTable[r][0]);
      end
    end
    return 2 * total + 1000;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic run_row(input int words, input int mode, input int div);
    int          sent;
    int          cycle;
    int          stall_len;
    logic [31:0] bits;
    sent      = 0;
    cycle     = 0;
    stall_len = stall_cycles(div);
    while (in_valid || sent < words || pending != 0 ||
           credit_level != CreditWidth'(NumCredits)) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        sent++;
      end
      // A word stays on the input until it is taken
      if (sent >= words) begin
        in_valid <= 1'b0;
      end else if (!in_valid || in_ready) begin
        draw_bits(DataWidth, bits);
        in_data <= bits[DataWidth-1:0];
        if (mode == ReadyRandom) begin
          draw_bits(1, bits);
          in_valid <= bits[0];
        end else begin
          in_valid <= 1'b1;
        end
      end
      case (mode)
        ReadyRandom: begin
          draw_bits(1, bits);
          out_ready <= bits[0];
        end
        ReadyStall: begin
          if (cycle == stall_len && in_ready) begin
            $display("FAIL %0t ready_o expected 0 got %0h", $time, in_ready);
            stim_errors++;
          end
          out_ready <= (cycle >= stall_len);
        end
        default: out_ready <= 1'b1;
      endcase
      cycle++;
    end
  endtask

  initial begin : stimulus
    int r;
    clk_div   = ClkDivWidth'(StimTable[0][0]);
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    rst_n     = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (r = 0; r < NumRows; r++) begin
      @(posedge clk);
      clk_div <= ClkDivWidth'(StimTable[r][0]);
      run_row(StimTable[r][1], StimTable[r][2], StimTable[r][0]);
    end
    @(posedge clk);
    $display("Checked %0d words, %0d checker errors, %0d stimulus errors, %0d assertion errors",
             checked, chk_errors, stim_errors, assert_errors);
    if (chk_errors == 0 && stim_errors == 0 && assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the link drained", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* vlog.f */
serial_link_pkg.sv
serial_link_recv_fifo.sv
serial_link_network.sv
serial_link_data_link.sv
serial_link_physical.sv
serial_link.sv
serial_link_asserts.sv
serial_link_checker.sv
tb_serial_link.sv
